//--- build.f
+incdir+.
vp_pkg.sv
sync_fifo.sv
udp_transmit_handler.sv
internet_checksum_calculator.sv
frame_check_sequence_generator.sv
ethernet_frame_generator.sv
virtual_port_udp.sv
tb_virtual_port_udp.sv

//--- Bender.yml
package:
  name: virtual_port_udp

export_include_dirs:
  - .

sources:
  - files:
      - vp_pkg.sv
      - sync_fifo.sv
      - udp_transmit_handler.sv
      - internet_checksum_calculator.sv
      - frame_check_sequence_generator.sv
      - ethernet_frame_generator.sv
      - virtual_port_udp.sv
  - target: test
    files:
      - tb_virtual_port_udp.sv

//--- tb_virtual_port_udp.sv
//////////////////////////////////////////////////
// Testbench for the UDP virtual port transmit side
// Random payloads checked against a frame model
//////////////////////////////////////////////////
`include "vp_cfg.svh"

module tb_virtual_port_udp;

    localparam int CLOCK_PERIOD  = 10;
    localparam int FRAME_COUNT   = 41;
    localparam int ENABLE_FREE   = 0;
    localparam int ENABLE_RANDOM = 1;
    localparam int ENABLE_HOLD   = 2;

    logic                 clock = 1'b0;
    logic                 reset;
    vp_pkg::mac_addr_t    mac_source;
    vp_pkg::mac_addr_t    mac_destination;
    vp_pkg::ipv4_addr_t   ipv4_source;
    vp_pkg::ipv4_addr_t   ipv4_destination;
    vp_pkg::udp_port_t    udp_source;
    vp_pkg::udp_port_t    udp_destination;
    vp_pkg::stream_word_t module_transmit_data;
    logic                 module_transmit_data_enable;
    logic                 module_transmit_data_ready;
    vp_pkg::stream_word_t transmit_data;
    logic                 transmit_data_valid;
    logic                 transmit_data_enable;

    vp_pkg::stream_word_t expected_words[$];    // Model output for all pending frames
    vp_pkg::length_t      expected_lengths[$];
    vp_pkg::byte_t        current_payload[$];
    vp_pkg::byte_t        frame_bytes[$];
    vp_pkg::length_t      received_count = '0;
    vp_pkg::length_t      model_identification = '0;
    int                   error_count = 0;
    int                   tests_failed = 0;
    int                   test_start_errors = 0;
    int                   next_frame = 0;
    int                   enable_mode = ENABLE_FREE;
    int                   plan_length[FRAME_COUNT];
    longint               watchdog_limit;
    logic                 plan_ready = 1'b0;

    virtual_port_udp dut_i (
        .clock                       (clock),
        .reset                       (reset),
        .mac_source                  (mac_source),
        .mac_destination             (mac_destination),
        .ipv4_source                 (ipv4_source),
        .ipv4_destination            (ipv4_destination),
        .udp_source                  (udp_source),
        .udp_destination             (udp_destination),
        .module_transmit_data        (module_transmit_data),
        .module_transmit_data_enable (module_transmit_data_enable),
        .module_transmit_data_ready  (module_transmit_data_ready),
        .transmit_data               (transmit_data),
        .transmit_data_valid         (transmit_data_valid),
        .transmit_data_enable        (transmit_data_enable)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    //////////////////////////////////////////////////
    // Reference frame model
    //////////////////////////////////////////////////
    function automatic vp_pkg::fcs_t crc_byte(vp_pkg::fcs_t crc, vp_pkg::byte_t octet);
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            if (crc[0] ^ octet[bit_index])
                crc = (crc >> 1) ^ 32'hEDB88320;
            else
                crc = crc >> 1;
        end
        return crc;
    endfunction

    function automatic vp_pkg::checksum_t ipv4_checksum(vp_pkg::length_t total_length,
                                                        vp_pkg::length_t identification);
        logic [31:0] sum;
        sum = 32'h4500 + total_length + identification + `VP_IPV4_FLAGS
            + {`VP_TTL, 8'd17}
            + ipv4_source[31:16] + ipv4_source[15:0]
            + ipv4_destination[31:16] + ipv4_destination[15:0];
        while (sum[31:16] != 16'd0)
            sum = sum[15:0] + sum[31:16];   // End around carry
        return ~sum[15:0];
    endfunction

    task automatic add_bytes(input logic [63:0] value, input int count);
        for (int i = count - 1; i >= 0; i--)
            frame_bytes.push_back(value[i*8 +: 8]);     // Network order
    endtask

    task automatic expect_frame();
        vp_pkg::length_t      payload_length;
        vp_pkg::fcs_t         crc;
        vp_pkg::stream_word_t word;
        payload_length = vp_pkg::length_t'(current_payload.size());
        frame_bytes.delete();
        add_bytes(mac_destination, 6);
        add_bytes(mac_source, 6);
        add_bytes(`VP_ETHERTYPE, 2);
        add_bytes(8'h45, 1);
        add_bytes(8'h00, 1);
        add_bytes(payload_length + 16'd28, 2);
        add_bytes(model_identification, 2);
        add_bytes(`VP_IPV4_FLAGS, 2);
        add_bytes(`VP_TTL, 1);
        add_bytes(8'd17, 1);
        add_bytes(ipv4_checksum(payload_length + 16'd28, model_identification), 2);
        add_bytes(ipv4_source, 4);
        add_bytes(ipv4_destination, 4);
        add_bytes(udp_source, 2);
        add_bytes(udp_destination, 2);
        add_bytes(payload_length + 16'd8, 2);
        add_bytes(16'h0000, 2);                 // UDP checksum unused
        foreach (current_payload[i])
            frame_bytes.push_back(current_payload[i]);
        while (frame_bytes.size() < `VP_MIN_FRAME)
            frame_bytes.push_back(8'h00);
        crc = '1;
        foreach (frame_bytes[i])
            crc = crc_byte(crc, frame_bytes[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            frame_bytes.push_back(crc[i*8 +: 8]);
        foreach (frame_bytes[i]) begin
            word.data = frame_bytes[i];
            word.last = (i == frame_bytes.size() - 1);
            expected_words.push_back(word);
        end
        expected_lengths.push_back(vp_pkg::length_t'(frame_bytes.size()));
        model_identification = model_identification + 16'd1;
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(input vp_pkg::stream_word_t actual,
                              input vp_pkg::stream_word_t expected);
        if (actual !== expected) begin
            $display("** Error @ %0t: frame word last=%0b data=%02h, expected last=%0b data=%02h",
                     $time, actual.last, actual.data, expected.last, expected.data);
            error_count++;
        end
    endtask

    task automatic check_length(input vp_pkg::length_t actual, input vp_pkg::length_t expected);
        if (actual !== expected) begin
            $display("** Error @ %0t: frame of %0d bytes, expected %0d bytes",
                     $time, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("** Error @ %0t: %s is %0b, expected %0b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // Output side drives enable and samples on the falling edge
    always @(negedge clock) begin
        case (enable_mode)
            ENABLE_RANDOM: transmit_data_enable = ($urandom % 4) != 0;
            ENABLE_HOLD:   transmit_data_enable = 1'b0;
            default:       transmit_data_enable = 1'b1;
        endcase
        if (!reset && transmit_data_valid && transmit_data_enable) begin
            if (expected_words.size() == 0) begin
                $display("Output word at time %0t arrived with no frame pending", $time);
                error_count++;
            end else begin
                check_word(transmit_data, expected_words.pop_front());
                received_count = received_count + 16'd1;
                if (transmit_data.last) begin
                    check_length(received_count, expected_lengths.pop_front());
                    received_count = '0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic push_word(input vp_pkg::byte_t octet, input logic last);
        @(negedge clock);
        module_transmit_data.data   = octet;
        module_transmit_data.last   = last;
        module_transmit_data_enable = 1'b1;
        while (!module_transmit_data_ready)
            @(negedge clock);
        @(posedge clock);
    endtask

    task automatic send_next_frame();
        int length;
        length = plan_length[next_frame];
        next_frame++;
        current_payload.delete();
        for (int i = 0; i < length; i++)
            current_payload.push_back(vp_pkg::byte_t'($urandom));
        expect_frame();
        foreach (current_payload[i])
            push_word(current_payload[i], i == length - 1);
        @(negedge clock);
        module_transmit_data_enable = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset = 1'b1;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        model_identification = '0;
    endtask

    task automatic finish_test(input int number, input string name);
        while (expected_words.size() != 0)
            @(negedge clock);
        repeat (4) @(negedge clock);
        if (error_count == test_start_errors) begin
            $display("Test %0d %s: passed", number, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors",
                     number, name, error_count - test_start_errors);
            tests_failed++;
        end
        test_start_errors = error_count;
    endtask

    initial begin
        wait (plan_ready === 1'b1);
        #(watchdog_limit);
        $display("Run timed out at %0t before all expected frames came out", $time);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        longint total_bytes;
        reset                       = 1'b1;
        module_transmit_data        = '0;
        module_transmit_data_enable = 1'b0;
        transmit_data_enable        = 1'b0;
        mac_source                  = 48'h02_00_00_00_00_01;
        mac_destination             = 48'h02_00_00_00_00_02;
        ipv4_source                 = 32'hC0A8_0001;
        ipv4_destination            = 32'hC0A8_0002;
        udp_source                  = 16'd5000;
        udp_destination             = 16'd6000;
        void'($urandom(32'h770b7059));

        // Payload lengths for all tests size the watchdog
        total_bytes = 0;
        for (int i = 0; i < FRAME_COUNT; i++) begin
            if (i < 8)
                plan_length[i] = 18 + ($urandom % 47);
            else if (i < 16)
                plan_length[i] = 1 + ($urandom % 17);     // Padded frames
            else
                plan_length[i] = 1 + ($urandom % 64);
            total_bytes += plan_length[i];
        end
        watchdog_limit = (total_bytes + 80 * FRAME_COUNT) * 4 * CLOCK_PERIOD;
        plan_ready     = 1'b1;

        repeat (3) @(negedge clock);
        reset = 1'b0;

        repeat (8) send_next_frame();
        finish_test(1, "single frames of 18 to 64 bytes");

        repeat (8) send_next_frame();
        finish_test(2, "short payloads with padding");

        apply_reset();
        repeat (3) send_next_frame();
        finish_test(3, "identification from zero after reset");

        enable_mode = ENABLE_HOLD;      // Payloads pile up in the queues
        repeat (8) send_next_frame();   // Fills the length queue
        check_flag(module_transmit_data_ready, 1'b0, "input ready with length queue full");
        repeat (20) @(negedge clock);
        enable_mode = ENABLE_FREE;
        finish_test(4, "queued back to back payloads");

        enable_mode = ENABLE_RANDOM;
        repeat (10) send_next_frame();
        finish_test(5, "random output back pressure");
        enable_mode = ENABLE_FREE;

        @(negedge clock);
        mac_source       = {16'($urandom), $urandom};
        mac_destination  = {16'($urandom), $urandom};
        ipv4_source      = $urandom;
        ipv4_destination = $urandom;
        udp_source       = 16'($urandom);
        udp_destination  = 16'($urandom);
        repeat (4) send_next_frame();
        finish_test(6, "new address and port configuration");

        $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- virtual_port_udp.sv
//////////////////////////////////////////////////
// UDP virtual port, transmit side
// Payload and length queues feed the frame generator
//////////////////////////////////////////////////
`include "vp_cfg.svh"

module virtual_port_udp (
    input  logic                 clock,
    input  logic                 reset,
    input  vp_pkg::mac_addr_t    mac_source,
    input  vp_pkg::mac_addr_t    mac_destination,
    input  vp_pkg::ipv4_addr_t   ipv4_source,
    input  vp_pkg::ipv4_addr_t   ipv4_destination,
    input  vp_pkg::udp_port_t    udp_source,
    input  vp_pkg::udp_port_t    udp_destination,
    input  vp_pkg::stream_word_t module_transmit_data,          // From fabric
    input  logic                 module_transmit_data_enable,
    output logic                 module_transmit_data_ready,
    output vp_pkg::stream_word_t transmit_data,                 // To switch
    output logic                 transmit_data_valid,
    input  logic                 transmit_data_enable
);

    logic            payload_push;
    vp_pkg::byte_t   payload_push_byte;
    logic            payload_pop;
    vp_pkg::byte_t   payload_pop_byte;
    logic            payload_full;

    logic            length_push;
    vp_pkg::length_t length_push_data;
    logic            length_pop;
    vp_pkg::length_t length_pop_data;
    logic            length_empty;
    logic            length_full;

    udp_transmit_handler udp_transmit_handler (
        .clock        (clock),
        .reset        (reset),
        .data         (module_transmit_data),
        .data_enable  (module_transmit_data_enable),
        .data_ready   (module_transmit_data_ready),
        .payload_full (payload_full),
        .length_full  (length_full),
        .payload_push (payload_push),
        .payload_byte (payload_push_byte),
        .length_push  (length_push),
        .length       (length_push_data)
    );

    sync_fifo #(.T(vp_pkg::byte_t), .DEPTH(`VP_PAYLOAD_DEPTH)) payload_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (payload_push),
        .push_data (payload_push_byte),
        .pop       (payload_pop),
        .pop_data  (payload_pop_byte),
        .empty     (),                 // Length queue gates reads instead
        .full      (payload_full)
    );

    sync_fifo #(.T(vp_pkg::length_t), .DEPTH(`VP_LENGTH_DEPTH)) length_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (length_push),
        .push_data (length_push_data),
        .pop       (length_pop),
        .pop_data  (length_pop_data),
        .empty     (length_empty),
        .full      (length_full)
    );

    ethernet_frame_generator ethernet_frame_generator (
        .clock            (clock),
        .reset            (reset),
        .mac_source       (mac_source),
        .mac_destination  (mac_destination),
        .ipv4_source      (ipv4_source),
        .ipv4_destination (ipv4_destination),
        .udp_source       (udp_source),
        .udp_destination  (udp_destination),
        .length_empty     (length_empty),
        .length           (length_pop_data),
        .length_pop       (length_pop),
        .payload_byte     (payload_pop_byte),
        .payload_pop      (payload_pop),
        .frame_data       (transmit_data),
        .frame_valid      (transmit_data_valid),
        .frame_enable     (transmit_data_enable)
    );

endmodule

//--- ethernet_frame_generator.sv
//////////////////////////////////////////////////
// Ethernet II frame generator for UDP payloads
// Checksum pre-pass, then header, payload,
// padding and FCS on the output stream
//////////////////////////////////////////////////
`include "vp_cfg.svh"

module ethernet_frame_generator (
    input  logic                 clock,
    input  logic                 reset,
    input  vp_pkg::mac_addr_t    mac_source,
    input  vp_pkg::mac_addr_t    mac_destination,
    input  vp_pkg::ipv4_addr_t   ipv4_source,
    input  vp_pkg::ipv4_addr_t   ipv4_destination,
    input  vp_pkg::udp_port_t    udp_source,
    input  vp_pkg::udp_port_t    udp_destination,
    input  logic                 length_empty,
    input  vp_pkg::length_t      length,
    output logic                 length_pop,
    input  vp_pkg::byte_t        payload_byte,
    output logic                 payload_pop,
    output vp_pkg::stream_word_t frame_data,
    output logic                 frame_valid,
    input  logic                 frame_enable
);

    localparam int HEADER_BYTES = 42;   // MAC, IPv4 and UDP headers
    localparam int IPV4_FIRST   = 14;
    localparam int IPV4_LAST    = 33;

    vp_pkg::frame_state_t      state;
    vp_pkg::length_t           byte_index;
    logic [1:0]                fcs_index;
    vp_pkg::length_t           identification;
    vp_pkg::length_t           payload_end;
    vp_pkg::length_t           frame_end;
    logic [HEADER_BYTES*8-1:0] header;
    vp_pkg::byte_t             header_byte;
    vp_pkg::byte_t             body_byte;
    logic                      transfer;

    logic                      checksum_start;
    vp_pkg::byte_t             checksum_data;
    logic                      checksum_enable;
    logic                      checksum_last;
    vp_pkg::checksum_t         checksum_result;
    logic                      checksum_valid;
    logic                      fcs_start;
    vp_pkg::byte_t             fcs_data;
    logic                      fcs_enable;
    vp_pkg::fcs_t              fcs;

    internet_checksum_calculator ipv4_checksum_calculator (
        .clock        (clock),
        .reset        (reset),
        .start        (checksum_start),
        .data         (checksum_data),
        .data_enable  (checksum_enable),
        .data_last    (checksum_last),
        .result       (checksum_result),
        .result_valid (checksum_valid)
    );

    frame_check_sequence_generator frame_check_sequence_generator (
        .clock       (clock),
        .reset       (reset),
        .start       (fcs_start),
        .data        (fcs_data),
        .data_enable (fcs_enable),
        .checksum    (fcs)
    );

    //////////////////////////////////////////////////
    // Header bytes and frame layout
    //////////////////////////////////////////////////
    assign payload_end = length + 16'(HEADER_BYTES);
    assign frame_end   = (payload_end < 16'(`VP_MIN_FRAME)) ? 16'(`VP_MIN_FRAME) : payload_end;

    // Checksum field stays zero during the pre-pass
    assign header = {mac_destination, mac_source, `VP_ETHERTYPE,
                     `VP_IPV4_VERSION_IHL, 8'h00, length + 16'd28, identification,
                     `VP_IPV4_FLAGS, `VP_TTL, `VP_IPV4_PROTOCOL,
                     (state == vp_pkg::FRAME_SEND) ? checksum_result : 16'h0000,
                     ipv4_source, ipv4_destination,
                     udp_source, udp_destination, length + 16'd8, 16'h0000};

    always_comb begin
        header_byte = 8'h00;
        if (byte_index < HEADER_BYTES)
            header_byte = header[(HEADER_BYTES - 1 - byte_index) * 8 +: 8];
        if (byte_index < HEADER_BYTES)
            body_byte = header_byte;
        else if (byte_index < payload_end)
            body_byte = payload_byte;
        else
            body_byte = 8'h00;              // Pad to minimum frame
    end

    always_comb begin
        frame_data = '0;
        if (state == vp_pkg::FRAME_FCS) begin
            frame_data.data = fcs[fcs_index*8 +: 8];   // Low byte first
            frame_data.last = (fcs_index == 2'd3);
        end else begin
            frame_data.data = body_byte;
        end
    end

    assign frame_valid = (state == vp_pkg::FRAME_SEND) || (state == vp_pkg::FRAME_FCS);
    assign transfer    = frame_valid && frame_enable;
    assign payload_pop = (state == vp_pkg::FRAME_SEND) && transfer &&
                         (byte_index >= HEADER_BYTES) && (byte_index < payload_end);
    assign length_pop  = (state == vp_pkg::FRAME_FCS) && transfer && (fcs_index == 2'd3);

    assign checksum_start  = (state == vp_pkg::FRAME_IDLE) && !length_empty;
    assign checksum_data   = header_byte;
    assign checksum_enable = (state == vp_pkg::FRAME_CHECKSUM);
    assign checksum_last   = (byte_index == 16'(IPV4_LAST));
    assign fcs_start       = checksum_start;
    assign fcs_data        = body_byte;
    assign fcs_enable      = (state == vp_pkg::FRAME_SEND) && transfer;

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= vp_pkg::FRAME_IDLE;
            byte_index     <= '0;
            fcs_index      <= '0;
            identification <= '0;
        end else begin
            case (state)
                vp_pkg::FRAME_IDLE: begin
                    if (!length_empty) begin
                        state      <= vp_pkg::FRAME_CHECKSUM;
                        byte_index <= 16'(IPV4_FIRST);
                    end
                end
                vp_pkg::FRAME_CHECKSUM: begin
                    if (checksum_last)
                        state <= vp_pkg::FRAME_CHECKSUM_WAIT;
                    else
                        byte_index <= byte_index + 16'd1;
                end
                vp_pkg::FRAME_CHECKSUM_WAIT: begin
                    if (checksum_valid) begin
                        state      <= vp_pkg::FRAME_SEND;
                        byte_index <= '0;
                    end
                end
                vp_pkg::FRAME_SEND: begin
                    if (transfer) begin
                        byte_index <= byte_index + 16'd1;
                        if (byte_index == frame_end - 16'd1) begin
                            state     <= vp_pkg::FRAME_FCS;
                            fcs_index <= '0;
                        end
                    end
                end
                vp_pkg::FRAME_FCS: begin
                    if (transfer) begin
                        fcs_index <= fcs_index + 2'd1;
                        if (fcs_index == 2'd3) begin
                            state          <= vp_pkg::FRAME_IDLE;
                            identification <= identification + 16'd1;
                        end
                    end
                end
                default: state <= vp_pkg::FRAME_IDLE;
            endcase
        end
    end

endmodule

//--- frame_check_sequence_generator.sv
//////////////////////////////////////////////////
// Ethernet FCS, reflected CRC-32
// One byte per clock, inverted output
//////////////////////////////////////////////////
`include "vp_cfg.svh"

module frame_check_sequence_generator (
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  vp_pkg::byte_t data,
    input  logic          data_enable,
    output vp_pkg::fcs_t  checksum
);

    vp_pkg::fcs_t crc;

    // LSB first, one shift per bit
    function automatic vp_pkg::fcs_t crc_step(vp_pkg::fcs_t value, vp_pkg::byte_t octet);
        vp_pkg::fcs_t next;
        next = value ^ {24'd0, octet};
        for (int i = 0; i < 8; i++) begin
            if (next[0])
                next = (next >> 1) ^ `VP_CRC32_POLY;
            else
                next = next >> 1;
        end
        return next;
    endfunction

    assign checksum = ~crc;

    always_ff @(posedge clock) begin
        if (reset || start)
            crc <= '1;
        else if (data_enable)
            crc <= crc_step(crc, data);
    end

endmodule

//--- internet_checksum_calculator.sv
//////////////////////////////////////////////////
// Internet checksum over a byte stream
// Big endian word pairs, end around carry
//////////////////////////////////////////////////
module internet_checksum_calculator (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  vp_pkg::byte_t     data,
    input  logic              data_enable,
    input  logic              data_last,
    output vp_pkg::checksum_t result,
    output logic              result_valid
);

    logic              byte_pending;    // High byte of a word is held
    vp_pkg::byte_t     high_byte;
    vp_pkg::checksum_t sum;
    vp_pkg::checksum_t next_sum;
    logic [15:0]       word;
    logic [16:0]       word_sum;

    always_comb begin
        word     = byte_pending ? {high_byte, data} : {data, 8'h00};
        word_sum = {1'b0, sum} + {1'b0, word};
        next_sum = word_sum[15:0] + {15'd0, word_sum[16]};
    end

    always_ff @(posedge clock) begin
        if (reset || start) begin
            byte_pending <= 1'b0;
            sum          <= '0;
            result_valid <= 1'b0;
        end else if (data_enable) begin
            high_byte <= data;
            if (byte_pending || data_last)
                sum <= next_sum;    // Odd tail padded with zero
            byte_pending <= !byte_pending && !data_last;
            if (data_last) begin
                result       <= ~next_sum;
                result_valid <= 1'b1;
            end
        end
    end

endmodule

//--- udp_transmit_handler.sv
//////////////////////////////////////////////////
// UDP transmit handler
// Splits payload words into the byte queue and
// counts each payload for the length queue
//////////////////////////////////////////////////
module udp_transmit_handler (
    input  logic                 clock,
    input  logic                 reset,
    input  vp_pkg::stream_word_t data,
    input  logic                 data_enable,
    output logic                 data_ready,
    input  logic                 payload_full,
    input  logic                 length_full,
    output logic                 payload_push,
    output vp_pkg::byte_t        payload_byte,
    output logic                 length_push,
    output vp_pkg::length_t      length
);

    vp_pkg::length_t byte_count;    // Bytes taken so far in this payload
    logic            accept;

    // Queues do not guard themselves
    assign data_ready = !payload_full && !length_full;
    assign accept     = data_enable && data_ready;

    // Byte and length land in the queues on the accepting edge
    assign payload_push = accept;
    assign payload_byte = data.data;
    assign length_push  = accept && data.last;
    assign length       = byte_count + 16'd1;   // Includes current byte

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count <= '0;
        end else if (accept) begin
            if (data.last)
                byte_count <= '0;
            else
                byte_count <= length;
        end
    end

endmodule

//--- sync_fifo.sv
//////////////////////////////////////////////////
// Single clock queue, first word fall through
// Entry type set by parameter
//////////////////////////////////////////////////
module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] write_ptr;
    logic [PTR_W-1:0] read_ptr;
    logic [CNT_W-1:0] count;

    assign pop_data = mem[read_ptr];    // Head is always visible
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge clock) begin
        if (push)
            mem[write_ptr] <= push_data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (push)
                write_ptr <= (write_ptr == PTR_W'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            if (pop)
                read_ptr <= (read_ptr == PTR_W'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- vp_pkg.sv
//////////////////////////////////////////////////
// UDP virtual port shared types
// Stream words, address fields and FSM states
//////////////////////////////////////////////////
package vp_pkg;

    // One octet of frame or payload
    typedef logic [7:0] byte_t;

    // Stream word, last marks the final byte
    typedef struct packed {
        logic  last;
        byte_t data;
    } stream_word_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;

    typedef logic [15:0] length_t;     // Bytes
    typedef logic [15:0] checksum_t;   // One's complement
    typedef logic [31:0] fcs_t;        // CRC-32

    //////////////////////////////////////////////////
    // Frame generator states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        FRAME_IDLE,
        FRAME_CHECKSUM,         // IPv4 header pre-pass
        FRAME_CHECKSUM_WAIT,
        FRAME_SEND,             // Header, payload, padding
        FRAME_FCS
    } frame_state_t;

endpackage

//--- vp_cfg.svh
//////////////////////////////////////////////////
// UDP virtual port constants
// Queue depths and fixed protocol header values
//////////////////////////////////////////////////
`ifndef VP_CFG_SVH
`define VP_CFG_SVH

// Queue sizing
`define VP_PAYLOAD_DEPTH    2048
`define VP_LENGTH_DEPTH     8
`define VP_MAX_PAYLOAD      1472
`define VP_MIN_FRAME        60          // Before FCS

// Fixed header fields
`define VP_ETHERTYPE        16'h0800
`define VP_IPV4_VERSION_IHL 8'h45
`define VP_IPV4_FLAGS       16'h4000
`define VP_TTL              8'd64
`define VP_IPV4_PROTOCOL    8'd17       // UDP
`define VP_CRC32_POLY       32'hEDB88320

`endif
